// ==== verilog/mfp_pkg.sv ====
`default_nettype none

package mfp_pkg;

    // AHB-Lite transfer type
    typedef enum logic [1:0]
    {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // register picked by an address phase
    typedef enum logic [2:0]
    {
        SEL_NONE,
        SEL_RED,
        SEL_GREEN,
        SEL_SWITCH,
        SEL_BUTTON,
        SEL_ALS,
        SEL_RESET
    } reg_sel_e;

    // peripheral window on address bits [31:8]
    localparam logic [23:0] GPIO_BASE   = 24'h1f8000;

    // word offsets on address bits [7:0]
    localparam logic [7:0]  ADDR_RED    = 8'h00;
    localparam logic [7:0]  ADDR_GREEN  = 8'h04;
    localparam logic [7:0]  ADDR_SWITCH = 8'h08;
    localparam logic [7:0]  ADDR_BUTTON = 8'h0c;
    localparam logic [7:0]  ADDR_ALS    = 8'h10;
    localparam logic [7:0]  ADDR_RESET  = 8'h14;

    // board port widths
    localparam int RED_W    = 18;
    localparam int GREEN_W  = 9;
    localparam int BUTTON_W = 5;
    localparam int ALS_W    = 16;

    // sensor frame timing of 136 cycles per frame
    localparam int SPI_HALF  = 4;
    localparam int SPI_GAP   = 8;
    localparam int SPI_CNT_W = $clog2(SPI_GAP > SPI_HALF ? SPI_GAP : SPI_HALF);
    localparam int SPI_BIT_W = $clog2(ALS_W);

    localparam int CORE_RESET_CYCLES = 16;
    localparam int RST_CNT_W         = $clog2(CORE_RESET_CYCLES + 1);

endpackage

`default_nettype wire

// ==== verilog/mfp_bus_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module mfp_bus_decoder
    import mfp_pkg::*;
(
    input  logic                clk,
    input  logic                reset,

    input  logic [31:0]         haddr,
    input  logic [1:0]          htrans,
    input  logic                hwrite,
    input  logic [31:0]         hwdata,
    output logic [31:0]         hrdata,

    input  logic [RED_W-1:0]    red_leds,
    input  logic [GREEN_W-1:0]  green_leds,
    input  logic [RED_W-1:0]    switches_sync,
    input  logic [BUTTON_W-1:0] buttons_sync,
    input  logic [ALS_W-1:0]    als_value,
    input  logic                core_reset,

    output logic                red_we,
    output logic                green_we,
    output logic                soft_reset
);

    htrans_e  trans;
    logic     xfer;
    reg_sel_e sel_next;
    reg_sel_e sel_q;
    logic     write_q;

    assign trans = htrans_e'(htrans);
    // BUSY and IDLE carry no transfer
    assign xfer  = (trans == NONSEQ) || (trans == SEQ);

    always_comb
    begin
        sel_next = SEL_NONE;
        if (haddr[31:8] == GPIO_BASE)
        begin
            case (haddr[7:0])
                ADDR_RED:    sel_next = SEL_RED;
                ADDR_GREEN:  sel_next = SEL_GREEN;
                ADDR_SWITCH: sel_next = SEL_SWITCH;
                ADDR_BUTTON: sel_next = SEL_BUTTON;
                ADDR_ALS:    sel_next = SEL_ALS;
                ADDR_RESET:  sel_next = SEL_RESET;
                default:     sel_next = SEL_NONE;
            endcase
        end
    end

    // address phase captured for the data phase
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sel_q   <= SEL_NONE;
            write_q <= 1'b0;
        end
        else
        begin
            sel_q   <= xfer ? sel_next : SEL_NONE;
            write_q <= xfer && hwrite;
        end
    end

    // one-cycle strobes alongside hwdata
    assign red_we     = write_q && (sel_q == SEL_RED);
    assign green_we   = write_q && (sel_q == SEL_GREEN);
    assign soft_reset = write_q && (sel_q == SEL_RESET) && hwdata[0];

    // read data zero extended to 32 bits
    always_comb
    begin
        case (sel_q)
            SEL_RED:    hrdata = {{(32 - RED_W){1'b0}}, red_leds};
            SEL_GREEN:  hrdata = {{(32 - GREEN_W){1'b0}}, green_leds};
            SEL_SWITCH: hrdata = {{(32 - RED_W){1'b0}}, switches_sync};
            SEL_BUTTON: hrdata = {{(32 - BUTTON_W){1'b0}}, buttons_sync};
            SEL_ALS:    hrdata = {{(32 - ALS_W){1'b0}}, als_value};
            SEL_RESET:  hrdata = {31'b0, core_reset};
            default:    hrdata = 32'b0;
        endcase
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        $onehot0({red_we, green_we, soft_reset}));

endmodule

`default_nettype wire

// ==== verilog/mfp_gpio_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module mfp_gpio_regs
    import mfp_pkg::*;
(
    input  logic                clk,
    input  logic                reset,

    input  logic                red_we,
    input  logic                green_we,
    input  logic [31:0]         wdata,

    input  logic [RED_W-1:0]    switches,
    input  logic [BUTTON_W-1:0] buttons,

    output logic [RED_W-1:0]    red_leds,
    output logic [GREEN_W-1:0]  green_leds,
    output logic [RED_W-1:0]    switches_sync,
    output logic [BUTTON_W-1:0] buttons_sync
);

    logic [RED_W-1:0]    switches_meta;
    logic [BUTTON_W-1:0] buttons_meta;

    // LED registers drive the pins directly
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            red_leds   <= '0;
            green_leds <= '0;
        end
        else
        begin
            if (red_we)
                red_leds <= wdata[RED_W-1:0];
            if (green_we)
                green_leds <= wdata[GREEN_W-1:0];
        end
    end

    // two-flop synchronizers for the asynchronous board inputs
    always_ff @(posedge clk)
    begin
        switches_meta <= switches;
        switches_sync <= switches_meta;
        buttons_meta  <= buttons;
        buttons_sync  <= buttons_meta;
    end

endmodule

`default_nettype wire

// ==== verilog/mfp_als_spi_receiver.sv ====
`timescale 1ns/10ps
`default_nettype none

module mfp_als_spi_receiver
    import mfp_pkg::*;
(
    input  logic             clk,
    input  logic             reset,

    input  logic             sdo,
    output logic             cs,
    output logic             sck,

    output logic [ALS_W-1:0] als_value
);

    typedef enum logic {GAP, SHIFT} spi_state_e;

    spi_state_e           state;
    logic [SPI_CNT_W-1:0] div_cnt;
    logic [SPI_BIT_W-1:0] bit_cnt;
    logic [ALS_W-1:0]     shift_reg;
    logic                 half_done;
    logic                 sample;
    logic                 frame_done;

    assign half_done  = (state == SHIFT) && (div_cnt == '0);
    // rising sck edge happens on this clock edge
    assign sample     = half_done && !sck;
    assign frame_done = half_done && sck && (bit_cnt == SPI_BIT_W'(ALS_W - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= GAP;
            cs      <= 1'b1;
            sck     <= 1'b1;
            div_cnt <= SPI_CNT_W'(SPI_GAP - 1);
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                GAP:
                begin
                    if (div_cnt == '0)
                    begin
                        // cs and sck fall together to open the frame
                        state   <= SHIFT;
                        cs      <= 1'b0;
                        sck     <= 1'b0;
                        div_cnt <= SPI_CNT_W'(SPI_HALF - 1);
                        bit_cnt <= '0;
                    end
                    else
                        div_cnt <= div_cnt - 1'b1;
                end
                SHIFT:
                begin
                    if (!half_done)
                        div_cnt <= div_cnt - 1'b1;
                    else if (!sck)
                    begin
                        sck     <= 1'b1;
                        div_cnt <= SPI_CNT_W'(SPI_HALF - 1);
                    end
                    else if (frame_done)
                    begin
                        state   <= GAP;
                        cs      <= 1'b1;
                        div_cnt <= SPI_CNT_W'(SPI_GAP - 1);
                    end
                    else
                    begin
                        sck     <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                        div_cnt <= SPI_CNT_W'(SPI_HALF - 1);
                    end
                end
            endcase
        end
    end

    // msb first
    always_ff @(posedge clk)
    begin
        if (sample)
            shift_reg <= {shift_reg[ALS_W-2:0], sdo};
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            als_value <= '0;
        else if (frame_done)
            als_value <= shift_reg;
    end

    a_sck_idle_high: assert property (@(posedge clk) disable iff (reset) cs |-> sck);

endmodule

`default_nettype wire

// ==== verilog/mfp_reset_seq.sv ====
`timescale 1ns/10ps
`default_nettype none

module mfp_reset_seq
    import mfp_pkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic soft_reset,
    input  logic trst_n_probe,

    output logic core_reset,
    output logic trst_n
);

    logic [RST_CNT_W-1:0] core_cnt;
    logic [RST_CNT_W-1:0] dbg_cnt;

    // core stretch restarted by either reset source
    always_ff @(posedge clk)
    begin
        if (reset || soft_reset)
            core_cnt <= RST_CNT_W'(CORE_RESET_CYCLES);
        else if (core_cnt != '0)
            core_cnt <= core_cnt - 1'b1;
    end

    // debug port stretch restarted by power-on reset only
    always_ff @(posedge clk)
    begin
        if (reset)
            dbg_cnt <= RST_CNT_W'(CORE_RESET_CYCLES);
        else if (dbg_cnt != '0)
            dbg_cnt <= dbg_cnt - 1'b1;
    end

    assign core_reset = (core_cnt != '0);
    // probe can still hold the debug port in reset
    assign trst_n     = (dbg_cnt == '0) && trst_n_probe;

    a_soft_reset_takes: assert property (@(posedge clk) disable iff (reset)
        soft_reset |=> core_reset);

endmodule

`default_nettype wire

// ==== verilog/mfp_system.sv ====
`timescale 1ns/10ps
`default_nettype none

module mfp_system
    import mfp_pkg::*;
(
    input  logic                clk,
    input  logic                reset,

    input  logic [31:0]         haddr,
    input  logic [1:0]          htrans,
    input  logic                hwrite,
    input  logic [31:0]         hwdata,
    output logic [31:0]         hrdata,

    input  logic [RED_W-1:0]    switches,
    input  logic [BUTTON_W-1:0] buttons,
    output logic [RED_W-1:0]    red_leds,
    output logic [GREEN_W-1:0]  green_leds,

    output logic                spi_cs,
    output logic                spi_sck,
    input  logic                spi_sdo,

    input  logic                trst_n_probe,
    output logic                trst_n,
    output logic                core_reset
);

    logic                red_we;
    logic                green_we;
    logic                soft_reset;
    logic [RED_W-1:0]    switches_sync;
    logic [BUTTON_W-1:0] buttons_sync;
    logic [ALS_W-1:0]    als_value;

    mfp_bus_decoder u_decoder
    (
        .clk           ( clk           ),
        .reset         ( reset         ),
        .haddr         ( haddr         ),
        .htrans        ( htrans        ),
        .hwrite        ( hwrite        ),
        .hwdata        ( hwdata        ),
        .hrdata        ( hrdata        ),
        .red_leds      ( red_leds      ),
        .green_leds    ( green_leds    ),
        .switches_sync ( switches_sync ),
        .buttons_sync  ( buttons_sync  ),
        .als_value     ( als_value     ),
        .core_reset    ( core_reset    ),
        .red_we        ( red_we        ),
        .green_we      ( green_we      ),
        .soft_reset    ( soft_reset    )
    );

    mfp_gpio_regs u_gpio
    (
        .clk           ( clk           ),
        .reset         ( reset         ),
        .red_we        ( red_we        ),
        .green_we      ( green_we      ),
        .wdata         ( hwdata        ),
        .switches      ( switches      ),
        .buttons       ( buttons       ),
        .red_leds      ( red_leds      ),
        .green_leds    ( green_leds    ),
        .switches_sync ( switches_sync ),
        .buttons_sync  ( buttons_sync  )
    );

    mfp_als_spi_receiver u_als
    (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .sdo       ( spi_sdo   ),
        .cs        ( spi_cs    ),
        .sck       ( spi_sck   ),
        .als_value ( als_value )
    );

    mfp_reset_seq u_reset_seq
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .soft_reset   ( soft_reset   ),
        .trst_n_probe ( trst_n_probe ),
        .core_reset   ( core_reset   ),
        .trst_n       ( trst_n       )
    );

endmodule

`default_nettype wire

// ==== tb/als_sensor_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module als_sensor_model
    import mfp_pkg::*;
(
    input  logic             sck,
    input  logic             cs,
    input  logic [ALS_W-1:0] word,
    output logic             sdo
);

    logic [ALS_W-1:0] frame_word;
    logic             armed;
    int               bit_idx;

    // word is frozen for a whole frame
    always @(negedge cs)
        frame_word <= word;

    // first sck fall arrives together with cs, so shifting waits for a rise
    always @(posedge sck or posedge cs)
    begin
        if (cs)
            armed <= 1'b0;
        else
            armed <= 1'b1;
    end

    // next bit goes out on each later falling sck
    always @(negedge sck or posedge cs)
    begin
        if (cs)
            bit_idx <= ALS_W - 1;
        else if (armed)
            bit_idx <= bit_idx - 1;
    end

    assign sdo = frame_word[bit_idx];

endmodule

`default_nettype wire

// ==== tb/tb_mfp_system.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mfp_system
    import mfp_pkg::*;
();

    localparam int          FRAME_CYCLES    = SPI_GAP + 32 * SPI_HALF;
    localparam int          WATCHDOG_CYCLES = 40 * FRAME_CYCLES + 2000;
    localparam logic [31:0] BASE            = {GPIO_BASE, 8'h00};

    logic                clk;
    logic                reset;
    logic [31:0]         haddr;
    logic [1:0]          htrans;
    logic                hwrite;
    logic [31:0]         hwdata;
    logic [31:0]         hrdata;
    logic [RED_W-1:0]    switches;
    logic [BUTTON_W-1:0] buttons;
    logic [RED_W-1:0]    red_leds;
    logic [GREEN_W-1:0]  green_leds;
    logic                spi_cs;
    logic                spi_sck;
    logic                spi_sdo;
    logic                trst_n_probe;
    logic                trst_n;
    logic                core_reset;
    logic [ALS_W-1:0]    sensor_word;

    // shadow of the register map
    logic [RED_W-1:0]    shadow_red;
    logic [GREEN_W-1:0]  shadow_green;
    logic [RED_W-1:0]    shadow_switches;
    logic [BUTTON_W-1:0] shadow_buttons;
    logic [ALS_W-1:0]    shadow_als;
    logic                shadow_core_reset;

    // read handed from address phase to data phase
    logic [31:0]         next_wdata;
    logic                req_read;
    logic [31:0]         req_expected;
    string               req_name;
    logic                chk_read;
    logic [31:0]         chk_expected;
    string               chk_name;
    int                  error_count;
    int                  check_count;

    mfp_system u_dut (.*);

    als_sensor_model u_sensor
    (
        .sck  ( spi_sck     ),
        .cs   ( spi_cs      ),
        .word ( sensor_word ),
        .sdo  ( spi_sdo     )
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        logic [31:0] value;
        value = '0;
        if (addr[31:8] == GPIO_BASE)
        begin
            case (addr[7:0])
                ADDR_RED:    value[RED_W-1:0]    = shadow_red;
                ADDR_GREEN:  value[GREEN_W-1:0]  = shadow_green;
                ADDR_SWITCH: value[RED_W-1:0]    = shadow_switches;
                ADDR_BUTTON: value[BUTTON_W-1:0] = shadow_buttons;
                ADDR_ALS:    value[ALS_W-1:0]    = shadow_als;
                ADDR_RESET:  value[0]            = shadow_core_reset;
                default:     value = '0;
            endcase
        end
        return value;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // one address phase plus the data phase of the transfer before it
    task automatic drive_phase(input logic [31:0] addr, input htrans_e trans,
                               input logic write, input logic [31:0] data, input string name);
        logic active;
        active = (trans == NONSEQ) || (trans == SEQ);
        @(negedge clk);
        hwdata       = next_wdata;
        haddr        = addr;
        htrans       = trans;
        hwrite       = write;
        next_wdata   = data;
        req_read     = active && !write;
        req_expected = expected_read(addr);
        req_name     = name;
        if (active && write && addr[31:8] == GPIO_BASE)
        begin
            case (addr[7:0])
                ADDR_RED:   shadow_red        = data[RED_W-1:0];
                ADDR_GREEN: shadow_green      = data[GREEN_W-1:0];
                ADDR_RESET: shadow_core_reset = shadow_core_reset | data[0];
                default:    ;
            endcase
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data, input string name);
        drive_phase(addr, NONSEQ, 1'b1, data, name);
    endtask

    task automatic bus_read(input logic [31:0] addr, input string name);
        drive_phase(addr, NONSEQ, 1'b0, $urandom, name);
    endtask

    task automatic idle_cycles(input int count);
        repeat (count)
            drive_phase(32'h0, IDLE, 1'b0, 32'h0, "idle");
    endtask

    task automatic wait_reset_release(input int limit, input string name);
        int cycles;
        cycles = 0;
        while ((core_reset || !trst_n) && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
        end
        check_count++;
        if (core_reset || !trst_n)
        begin
            error_count++;
            $display("%s: reset outputs still active after %0d cycles", name, limit);
        end
    endtask

    // hrdata is checked mid data phase
    always
    begin
        @(posedge clk);
        chk_read     = req_read;
        chk_expected = req_expected;
        chk_name     = req_name;
        @(negedge clk);
        if (chk_read)
            compare_value(chk_name, chk_expected, hrdata);
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial
    begin
        logic [31:0] value;
        void'($urandom(71));
        clk               = 1'b0;
        reset             = 1'b1;
        haddr             = '0;
        htrans            = IDLE;
        hwrite            = 1'b0;
        hwdata            = '0;
        switches          = '0;
        buttons           = '0;
        trst_n_probe      = 1'b1;
        sensor_word       = '0;
        next_wdata        = '0;
        req_read          = 1'b0;
        req_expected      = '0;
        req_name          = "";
        shadow_red        = '0;
        shadow_green      = '0;
        shadow_switches   = '0;
        shadow_buttons    = '0;
        shadow_als        = '0;
        shadow_core_reset = 1'b1;
        error_count       = 0;
        check_count       = 0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // power-on stretch and debug probe
        compare_value("core_reset at release", 32'h1, 32'(core_reset));
        compare_value("trst_n at release", 32'h0, 32'(trst_n));
        // sensor port idles with cs and sck high
        compare_value("spi_cs at release", 32'h1, 32'(spi_cs));
        compare_value("spi_sck at release", 32'h1, 32'(spi_sck));
        wait_reset_release(CORE_RESET_CYCLES + 2, "power-on");
        shadow_core_reset = 1'b0;
        trst_n_probe = 1'b0;
        @(negedge clk);
        compare_value("trst_n with probe low", 32'h0, 32'(trst_n));
        trst_n_probe = 1'b1;
        @(negedge clk);
        compare_value("trst_n with probe high", 32'h1, 32'(trst_n));

        // LED registers
        bus_read(BASE | ADDR_RED, "red reset value");
        bus_read(BASE | ADDR_GREEN, "green reset value");
        for (int i = 0; i < 8; i++)
        begin
            bus_write(BASE | ADDR_RED, $urandom, "red write");
            bus_read(BASE | ADDR_RED, "red read after write");
            bus_write(BASE | ADDR_GREEN, $urandom, "green write");
            bus_read(BASE | ADDR_GREEN, "green read after write");
            idle_cycles(1);
            compare_value("red_leds pins", 32'(shadow_red), 32'(red_leds));
            compare_value("green_leds pins", 32'(shadow_green), 32'(green_leds));
        end

        // switches and buttons through the synchronizers
        for (int i = 0; i < 6; i++)
        begin
            value           = $urandom;
            switches        = value[RED_W-1:0];
            buttons         = value[31:32-BUTTON_W];
            shadow_switches = switches;
            shadow_buttons  = buttons;
            idle_cycles(3);
            bus_read(BASE | ADDR_SWITCH, "switch read");
            bus_read(BASE | ADDR_BUTTON, "button read");
        end

        // light sensor words
        for (int i = 0; i < 4; i++)
        begin
            value       = $urandom;
            sensor_word = value[ALS_W-1:0];
            shadow_als  = sensor_word;
            idle_cycles(2 * FRAME_CYCLES);
            bus_read(BASE | ADDR_ALS, "als word");
        end

        // software reset
        bus_write(BASE | ADDR_RESET, 32'h1, "soft reset write");
        bus_read(BASE | ADDR_RESET, "reset register during stretch");
        idle_cycles(1);
        compare_value("core_reset after soft reset", 32'h1, 32'(core_reset));
        compare_value("trst_n during soft reset", 32'h1, 32'(trst_n));
        wait_reset_release(CORE_RESET_CYCLES + 2, "soft reset");
        shadow_core_reset = 1'b0;
        bus_read(BASE | ADDR_RESET, "reset register after stretch");
        bus_read(BASE | ADDR_RED, "red kept over soft reset");
        bus_read(BASE | ADDR_GREEN, "green kept over soft reset");
        bus_write(BASE | ADDR_RESET, 32'h2, "soft reset with bit 0 clear");
        idle_cycles(2);
        compare_value("core_reset with bit 0 clear", 32'h0, 32'(core_reset));

        // unmapped space and inactive transfers
        bus_read(BASE | 32'h18, "unmapped offset 0x18");
        bus_read(BASE | 32'hfc, "unmapped offset 0xfc");
        bus_read(BASE | 32'h02, "unaligned offset");
        bus_read({GPIO_BASE + 24'h1, ADDR_RED}, "read above window");
        bus_read({24'h0, ADDR_SWITCH}, "read at address zero page");
        bus_write({~GPIO_BASE, ADDR_RED}, $urandom, "write outside window");
        bus_write(BASE | 32'h18, $urandom, "write unmapped offset");
        drive_phase(BASE | ADDR_RED, IDLE, 1'b1, $urandom, "idle write");
        drive_phase(BASE | ADDR_GREEN, BUSY, 1'b1, $urandom, "busy write");
        drive_phase(BASE | ADDR_RESET, IDLE, 1'b1, 32'h1, "idle soft reset");
        idle_cycles(2);
        bus_read(BASE | ADDR_RED, "red after ignored writes");
        bus_read(BASE | ADDR_GREEN, "green after ignored writes");
        bus_read(BASE | ADDR_RESET, "reset register after ignored writes");
        idle_cycles(1);
        compare_value("red_leds after ignored writes", 32'(shadow_red), 32'(red_leds));
        compare_value("green_leds after ignored writes", 32'(shadow_green), 32'(green_leds));
        compare_value("core_reset after ignored writes", 32'h0, 32'(core_reset));
        idle_cycles(2);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/mfp_pkg.sv
verilog/mfp_bus_decoder.sv
verilog/mfp_gpio_regs.sv
verilog/mfp_als_spi_receiver.sv
verilog/mfp_reset_seq.sv
verilog/mfp_system.sv
tb/als_sensor_model.sv
tb/tb_mfp_system.sv

// ==== Bender.yml ====
package:
  name: mfp_system

sources:
  - files:
      - verilog/mfp_pkg.sv
      - verilog/mfp_bus_decoder.sv
      - verilog/mfp_gpio_regs.sv
      - verilog/mfp_als_spi_receiver.sv
      - verilog/mfp_reset_seq.sv
      - verilog/mfp_system.sv
  - target: test
    files:
      - tb/als_sensor_model.sv
      - tb/tb_mfp_system.sv
